/* logic/lsq_pkg.sv */
package lsq_pkg;

  parameter int ADDR_W    = 32;
  parameter int DATA_W    = 32;
  parameter int NUM_BANKS = 8;
  parameter int BANK_W    = $clog2(NUM_BANKS);

  typedef logic [ADDR_W-1:0]    addr_t;
  typedef logic [DATA_W-1:0]    data_t;
  typedef logic [1:0]           size_t;
  typedef logic [BANK_W-1:0]    bank_t;
  typedef logic [3:0]           ben_t;
  typedef logic [NUM_BANKS-1:0] bank_mask_t;
  typedef logic [2*DATA_W-1:0]  line_data_t;

  // n ones shifted by the byte offset, low nibble is the start bank
  function automatic logic [7:0] byte_mask(logic [1:0] off, size_t size);
    logic [7:0] ones;
    case (size)
      2'd0:    ones = 8'h01;
      2'd1:    ones = 8'h03;
      default: ones = 8'h0f;
    endcase
    return ones << off;
  endfunction

  // banks touched by one store
  function automatic bank_mask_t bank_mask(addr_t addr, size_t size);
    logic [7:0] bytes;
    bank_t      bank;
    bank_t      bank_nxt;
    bank_mask_t m;
    bytes    = byte_mask(addr[1:0], size);
    bank     = addr[2 +: BANK_W];
    bank_nxt = bank + 1'b1;
    m        = '0;
    m[bank]  = 1'b1;
    if (bytes[7:4] != 4'h0) begin
      m[bank_nxt] = 1'b1;
    end
    return m;
  endfunction

endpackage

/* logic/stq_peek_if.sv */
`timescale 1ns/1ps

interface stq_peek_if;

  // oldest entry
  logic            head0_valid;
  lsq_pkg::addr_t  head0_addr;
  lsq_pkg::size_t  head0_size;
  lsq_pkg::data_t  head0_data;

  // second oldest
  logic            head1_valid;
  lsq_pkg::addr_t  head1_addr;
  lsq_pkg::size_t  head1_size;
  lsq_pkg::data_t  head1_data;

  logic [1:0]      pop_count;

  modport queue (
    output head0_valid, head0_addr, head0_size, head0_data,
    output head1_valid, head1_addr, head1_size, head1_data,
    input  pop_count
  );

  modport issue (
    input  head0_valid, head0_addr, head0_size, head0_data,
    input  head1_valid, head1_addr, head1_size, head1_data,
    output pop_count
  );

endinterface

/* logic/wreq_if.sv */
`timescale 1ns/1ps

interface wreq_if;

  logic            en;
  lsq_pkg::addr_t  addr;
  lsq_pkg::size_t  size;
  lsq_pkg::data_t  data;

  modport source (
    output en, addr, size, data
  );

  modport sink (
    input en, addr, size, data
  );

endinterface

/* logic/store_queue.sv */
`timescale 1ns/1ps

module store_queue #(
  parameter int STQ_DEPTH = 8
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            flush,
  input  logic            in_valid,
  output logic            in_ready,
  input  lsq_pkg::addr_t  in_addr,
  input  lsq_pkg::size_t  in_size,
  input  lsq_pkg::data_t  in_data,
  stq_peek_if.queue       peek
);

  localparam int PTR_W = $clog2(STQ_DEPTH);

  lsq_pkg::addr_t addr_mem [STQ_DEPTH];
  lsq_pkg::size_t size_mem [STQ_DEPTH];
  lsq_pkg::data_t data_mem [STQ_DEPTH];

  logic [PTR_W-1:0] head;
  logic [PTR_W-1:0] head_nxt;
  logic [PTR_W-1:0] tail;
  logic [PTR_W:0]   count;
  logic             push;

  // no accept while flushing
  assign in_ready = !flush && (count < (PTR_W+1)'(STQ_DEPTH));
  assign push     = in_valid && in_ready;

  // pointer wraps since depth is a power of two
  assign head_nxt = head + 1'b1;

  assign peek.head0_valid = (count != '0);
  assign peek.head0_addr  = addr_mem[head];
  assign peek.head0_size  = size_mem[head];
  assign peek.head0_data  = data_mem[head];

  assign peek.head1_valid = (count > (PTR_W+1)'(1));
  assign peek.head1_addr  = addr_mem[head_nxt];
  assign peek.head1_size  = size_mem[head_nxt];
  assign peek.head1_data  = data_mem[head_nxt];

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      head  <= head + PTR_W'(peek.pop_count);
      count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(peek.pop_count);
      if (push) begin
        tail <= tail + 1'b1;
      end
    end
  end

  // entry storage
  always_ff @(posedge clk) begin
    if (push) begin
      addr_mem[tail] <= in_addr;
      size_mem[tail] <= in_size;
      data_mem[tail] <= in_data;
    end
  end

endmodule

/* logic/store_issue.sv */
`timescale 1ns/1ps

module store_issue (
  input  logic        clk,
  input  logic        rst,
  input  logic        flush,
  input  logic        st_stall,
  stq_peek_if.issue   peek,
  wreq_if.source      req0,
  wreq_if.source      req1
);

  logic                 stall_q;
  lsq_pkg::bank_mask_t  mask0;
  lsq_pkg::bank_mask_t  mask1;
  logic                 issue0;
  logic                 issue1;

  // cache stall is seen one cycle late
  always_ff @(posedge clk) begin
    if (rst) begin
      stall_q <= 1'b0;
    end else begin
      stall_q <= st_stall;
    end
  end

  assign mask0 = lsq_pkg::bank_mask(peek.head0_addr, peek.head0_size);
  assign mask1 = lsq_pkg::bank_mask(peek.head1_addr, peek.head1_size);

  assign issue0 = !stall_q && !flush && peek.head0_valid;
  // second port only on disjoint banks
  assign issue1 = issue0 && peek.head1_valid && ((mask0 & mask1) == '0);

  assign peek.pop_count = 2'(issue0) + 2'(issue1);

  always_ff @(posedge clk) begin
    if (rst) begin
      req0.en <= 1'b0;
      req1.en <= 1'b0;
    end else begin
      req0.en <= issue0;
      req1.en <= issue1;
    end
  end

  // request payload
  always_ff @(posedge clk) begin
    if (issue0) begin
      req0.addr <= peek.head0_addr;
      req0.size <= peek.head0_size;
      req0.data <= peek.head0_data;
    end
    if (issue1) begin
      req1.addr <= peek.head1_addr;
      req1.size <= peek.head1_size;
      req1.data <= peek.head1_data;
    end
  end

endmodule

/* logic/dcache_write_fmt.sv */
`timescale 1ns/1ps

module dcache_write_fmt (
  wreq_if.sink                 req,
  output logic                 st_en,
  output lsq_pkg::addr_t       st_addr,
  output lsq_pkg::bank_t       st_bank_bgn,
  output lsq_pkg::bank_t       st_bank_end,
  output lsq_pkg::ben_t        st_bgn_ben,
  output lsq_pkg::ben_t        st_end_ben,
  output lsq_pkg::line_data_t  st_data
);

  logic [7:0]      lane_mask;
  logic [7:0]      keep_mask;
  lsq_pkg::data_t  kept;
  logic [1:0]      off;

  assign off       = req.addr[1:0];
  assign lane_mask = lsq_pkg::byte_mask(off, req.size);

  assign st_en       = req.en;
  assign st_addr     = req.addr;
  assign st_bgn_ben  = lane_mask[3:0];
  assign st_end_ben  = lane_mask[7:4];
  assign st_bank_bgn = req.addr[2 +: lsq_pkg::BANK_W];
  // bank 7 spills over into bank 0
  assign st_bank_end = (lane_mask[7:4] != 4'h0) ? st_bank_bgn + 1'b1 : st_bank_bgn;

  // only the low n bytes survive
  assign keep_mask = lsq_pkg::byte_mask(2'd0, req.size);

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      kept[8*i +: 8] = keep_mask[i] ? req.data[8*i +: 8] : 8'h00;
    end
  end

  // move to byte lanes across start and end bank
  assign st_data = lsq_pkg::line_data_t'(kept) << {off, 3'b000};

endmodule

/* logic/store_path_top.sv */
`timescale 1ns/1ps

module store_path_top #(
  parameter int STQ_DEPTH = 8
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 flush,
  input  logic                 st_stall,
  input  logic                 in_valid,
  output logic                 in_ready,
  input  lsq_pkg::addr_t       in_addr,
  input  lsq_pkg::size_t       in_size,
  input  lsq_pkg::data_t       in_data,
  output logic                 st0_en,
  output lsq_pkg::addr_t       st0_addr,
  output lsq_pkg::bank_t       st0_bank_bgn,
  output lsq_pkg::bank_t       st0_bank_end,
  output lsq_pkg::ben_t        st0_bgn_ben,
  output lsq_pkg::ben_t        st0_end_ben,
  output lsq_pkg::line_data_t  st0_data,
  output logic                 st1_en,
  output lsq_pkg::addr_t       st1_addr,
  output lsq_pkg::bank_t       st1_bank_bgn,
  output lsq_pkg::bank_t       st1_bank_end,
  output lsq_pkg::ben_t        st1_bgn_ben,
  output lsq_pkg::ben_t        st1_end_ben,
  output lsq_pkg::line_data_t  st1_data
);

  stq_peek_if peek ();
  wreq_if     req0 ();
  wreq_if     req1 ();

  store_queue #(
    .STQ_DEPTH (STQ_DEPTH)
  ) u_store_queue (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .in_addr  (in_addr),
    .in_size  (in_size),
    .in_data  (in_data),
    .peek     (peek.queue)
  );

  store_issue u_store_issue (
    .clk      (clk),
    .rst      (rst),
    .flush    (flush),
    .st_stall (st_stall),
    .peek     (peek.issue),
    .req0     (req0.source),
    .req1     (req1.source)
  );

  // port 0 always holds the older store
  dcache_write_fmt u_fmt0 (
    .req         (req0.sink),
    .st_en       (st0_en),
    .st_addr     (st0_addr),
    .st_bank_bgn (st0_bank_bgn),
    .st_bank_end (st0_bank_end),
    .st_bgn_ben  (st0_bgn_ben),
    .st_end_ben  (st0_end_ben),
    .st_data     (st0_data)
  );

  dcache_write_fmt u_fmt1 (
    .req         (req1.sink),
    .st_en       (st1_en),
    .st_addr     (st1_addr),
    .st_bank_bgn (st1_bank_bgn),
    .st_bank_end (st1_bank_end),
    .st_bgn_ben  (st1_bgn_ben),
    .st_end_ben  (st1_end_ben),
    .st_data     (st1_data)
  );

endmodule

/* bench/tb_store_path.sv */
`timescale 1ns/1ps

module tb_store_path;

  logic clk, rst, flush, st_stall;
  logic in_valid, in_ready;
  lsq_pkg::addr_t in_addr, st0_addr, st1_addr;
  lsq_pkg::size_t in_size;
  lsq_pkg::data_t in_data;
  logic st0_en, st1_en;
  lsq_pkg::bank_t st0_bank_bgn, st0_bank_end, st1_bank_bgn, st1_bank_end;
  lsq_pkg::ben_t st0_bgn_ben, st0_end_ben, st1_bgn_ben, st1_end_ben;
  lsq_pkg::line_data_t st0_data, st1_data;

  // reference model in acceptance order
  lsq_pkg::addr_t exp_addr[$];
  lsq_pkg::size_t exp_size[$];
  lsq_pkg::data_t exp_data[$];

  int n_err = 0;
  int n_to = 0;

  store_path_top #(.STQ_DEPTH(8)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic compare_field(input string name, input logic [63:0] exp,
                               input logic [63:0] got);
    assert (got === exp) else begin
      $display("ERR %s expected %h got %h", name, exp, got);
      n_err++;
    end
  endtask

  task automatic score_store(input int port, input lsq_pkg::addr_t addr,
                             input lsq_pkg::bank_t bgn, input lsq_pkg::bank_t fin,
                             input lsq_pkg::ben_t ben0, input lsq_pkg::ben_t ben1,
                             input lsq_pkg::line_data_t data);
    lsq_pkg::addr_t ea;
    lsq_pkg::size_t es;
    lsq_pkg::data_t ed;
    int n;
    logic [7:0] lanes;
    logic [63:0] line;
    logic [2:0] e_bgn;
    logic [2:0] e_end;
    assert (exp_addr.size() != 0) else begin
      $display("st%0d_en rose with no accepted store left to match", port);
      n_err++;
    end
    if (exp_addr.size() == 0) begin
      return;
    end
    ea = exp_addr.pop_front();
    es = exp_size.pop_front();
    ed = exp_data.pop_front();
    n = 1 << es;
    lanes = 8'((1 << n) - 1);
    lanes = lanes << ea[1:0];
    line = 64'(ed & 32'((64'd1 << (8 * n)) - 64'd1));
    line = line << (8 * ea[1:0]);
    e_bgn = ea[4:2];
    // wraps from bank 7 to bank 0
    e_end = (lanes[7:4] != 4'h0) ? e_bgn + 3'd1 : e_bgn;
    compare_field($sformatf("st%0d_addr", port), 64'(ea), 64'(addr));
    compare_field($sformatf("st%0d_bank_bgn", port), 64'(e_bgn), 64'(bgn));
    compare_field($sformatf("st%0d_bank_end", port), 64'(e_end), 64'(fin));
    compare_field($sformatf("st%0d_bgn_ben", port), 64'(lanes[3:0]), 64'(ben0));
    compare_field($sformatf("st%0d_end_ben", port), 64'(lanes[7:4]), 64'(ben1));
    compare_field($sformatf("st%0d_data", port), line, data);
  endtask

  // st0 holds the older store and is scored first
  initial begin
    forever begin
      @(negedge clk);
      if (!rst && st0_en) begin
        score_store(0, st0_addr, st0_bank_bgn, st0_bank_end, st0_bgn_ben, st0_end_ben, st0_data);
      end
      if (!rst && st1_en) begin
        score_store(1, st1_addr, st1_bank_bgn, st1_bank_end, st1_bgn_ben, st1_end_ben, st1_data);
      end
      assert (rst || !st1_en || st0_en) else begin
        $display("st1_en is high while st0_en is low");
        n_err++;
      end
    end
  end

  task automatic push_expected(input lsq_pkg::addr_t a, input lsq_pkg::size_t s,
                               input lsq_pkg::data_t d);
    exp_addr.push_back(a);
    exp_size.push_back(s);
    exp_data.push_back(d);
  endtask

  // acceptance is decided from in_ready just after the falling edge
  task automatic enqueue(input lsq_pkg::addr_t a, input lsq_pkg::size_t s,
                         input lsq_pkg::data_t d);
    int t;
    @(negedge clk);
    in_valid = 1'b1;
    in_addr = a;
    in_size = s;
    in_data = d;
    #1;
    t = 0;
    while (!in_ready && t < 100) begin
      @(negedge clk);
      #1;
      t++;
    end
    if (in_ready) begin
      push_expected(a, s, d);
    end else begin
      $display("timed out waiting for in_ready");
      n_to++;
    end
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  task automatic await_issue(output logic dual);
    int t;
    dual = 1'b0;
    for (t = 0; t < 100; t++) begin
      @(negedge clk);
      if (st0_en) begin
        break;
      end
    end
    if (t == 100) begin
      $display("timed out waiting for st0_en");
      n_to++;
    end
    dual = st1_en;
  endtask

  task automatic wait_empty();
    int t;
    for (t = 0; t < 300; t++) begin
      @(negedge clk);
      #2;
      if (exp_addr.size() == 0) begin
        break;
      end
    end
    if (t == 300) begin
      $display("timed out waiting for %0d stores to leave", exp_addr.size());
      n_to++;
    end
  endtask

  task automatic single_store_format();
    logic dual;
    lsq_pkg::addr_t a;
    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 4; o++) begin
        a = $urandom;
        a[4:2] = 3'((s * 4 + o + 5) % 8);
        a[1:0] = 2'(o);
        enqueue(a, lsq_pkg::size_t'(s), $urandom);
        await_issue(dual);
        assert (!dual) else begin
          $display("st1_en rose together with a lone store");
          n_err++;
        end
      end
    end
  endtask

  task automatic dual_issue();
    logic dual;
    @(negedge clk);
    st_stall = 1'b1;
    enqueue(32'h0000_1004, 2'd2, $urandom);
    enqueue(32'h0000_200d, 2'd0, $urandom);
    @(negedge clk);
    st_stall = 1'b0;
    await_issue(dual);
    assert (dual) else begin
      $display("two stores on disjoint banks did not issue together");
      n_err++;
    end
    wait_empty();
  endtask

  task automatic bank_conflict();
    logic dual;
    @(negedge clk);
    st_stall = 1'b1;
    // first store spans banks 2 and 3
    enqueue(32'h0000_300a, 2'd2, $urandom);
    enqueue(32'h0000_400c, 2'd0, $urandom);
    @(negedge clk);
    st_stall = 1'b0;
    await_issue(dual);
    assert (!dual) else begin
      $display("stores sharing bank 3 issued in the same cycle");
      n_err++;
    end
    await_issue(dual);
    wait_empty();
  endtask

  task automatic back_pressure();
    @(negedge clk);
    st_stall = 1'b1;
    for (int i = 0; i < 8; i++) begin
      enqueue($urandom, lsq_pkg::size_t'($urandom % 3), $urandom);
    end
    for (int i = 0; i < 2; i++) begin
      @(negedge clk);
      in_valid = 1'b1;
      in_addr = $urandom;
      in_data = $urandom;
      #1;
      assert (!in_ready) else begin
        $display("in_ready is high with a full queue");
        n_err++;
      end
    end
    @(negedge clk);
    in_valid = 1'b0;
    st_stall = 1'b0;
    wait_empty();
    assert (in_ready) else begin
      $display("in_ready stayed low after the queue drained");
      n_err++;
    end
  endtask

  task automatic flush_queue();
    @(negedge clk);
    st_stall = 1'b1;
    for (int i = 0; i < 4; i++) begin
      enqueue($urandom, lsq_pkg::size_t'($urandom % 3), $urandom);
    end
    @(negedge clk);
    flush = 1'b1;
    exp_addr.delete();
    exp_size.delete();
    exp_data.delete();
    @(negedge clk);
    flush = 1'b0;
    st_stall = 1'b0;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      assert (!st0_en && !st1_en) else begin
        $display("a store issued after the flush");
        n_err++;
      end
    end
    enqueue($urandom, 2'd2, $urandom);
    wait_empty();
  endtask

  task automatic random_stream();
    int sent;
    int cyc;
    sent = 0;
    cyc = 0;
    while (sent < 200 && cyc < 5000) begin
      @(negedge clk);
      st_stall = ($urandom % 4) == 0;
      in_valid = ($urandom % 3) != 0;
      in_addr = $urandom;
      in_size = lsq_pkg::size_t'($urandom % 3);
      in_data = $urandom;
      #1;
      if (in_valid && in_ready) begin
        push_expected(in_addr, in_size, in_data);
        sent++;
      end
      cyc++;
    end
    if (sent < 200) begin
      $display("timed out with only %0d random stores accepted", sent);
      n_to++;
    end
    @(negedge clk);
    in_valid = 1'b0;
    st_stall = 1'b0;
    wait_empty();
    // a leftover entry would still issue here
    repeat (4) @(negedge clk);
    assert (in_ready) else begin
      $display("in_ready low after the random stream drained");
      n_err++;
    end
  endtask

  initial begin
    void'($urandom(32'h80b1aefb));
    rst = 1'b1;
    flush = 1'b0;
    st_stall = 1'b0;
    in_valid = 1'b0;
    in_addr = '0;
    in_size = '0;
    in_data = '0;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    assert (!st0_en && !st1_en && in_ready) else begin
      $display("outputs are not idle after reset");
      n_err++;
    end
    single_store_format();
    dual_issue();
    bank_conflict();
    back_pressure();
    flush_queue();
    random_stream();
    $display("errors: %0d, timeouts: %0d", n_err, n_to);
    if (n_err == 0 && n_to == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* compile.f */
logic/lsq_pkg.sv
logic/stq_peek_if.sv
logic/wreq_if.sv
logic/store_queue.sv
logic/store_issue.sv
logic/dcache_write_fmt.sv
logic/store_path_top.sv
bench/tb_store_path.sv

/* run.sh */
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_store_path -f compile.f &&
./obj_dir/Vtb_store_path > sim.log &&
cat sim.log &&
! grep -q "Some tests failed" sim.log || {
  echo "simulation failed, see sim.log"
  exit 1
}
